// File: hdl/bbm_pkg.sv
// bayesian memory shared definitions
package bbm_pkg;

  typedef logic [31:0] word_t;
  typedef logic [13:0] host_addr_t;
  typedef logic [10:0] word_addr_t;
  typedef logic [7:0]  cell_row_t;
  typedef logic [7:0]  cell_col_t;
  typedef logic [7:0]  lane_byte_t;
  typedef logic [15:0] pulse_len_t;
  typedef logic [8:0]  operand_t;

  typedef enum logic [3:0] {
    IDLE,
    RD_SETUP,
    RD_PRECHARGE,
    RD_PULSE,
    RD_PAUSE,
    RD_OUT,
    WR_ADDR,
    WR_PRECHARGE,
    WR_PULSE,
    WR_CUTOFF
  } seq_state_t;

  localparam int NUM_LANES  = 4;
  localparam int WORD_BITS  = 32;
  localparam int BYTE_BITS  = 8;
  localparam int NUM_PASSES = 4;

  // memory occupies host addresses below MEM_LIMIT
  localparam host_addr_t MEM_LIMIT    = 14'h2000;
  localparam host_addr_t RESULT_ADDR  = 14'h2000;
  localparam host_addr_t MODE_ADDR    = 14'h2004;
  localparam host_addr_t PULSE_ADDR   = 14'h2008;
  localparam host_addr_t OPERAND_BASE = 14'h200C;

  localparam int PRECHARGE_CYCLES = 3;
  localparam pulse_len_t PULSE_RESET_VALUE = 16'd1;

endpackage

// File: hdl/seq_cmd_if.sv
// sequencer command bus
interface seq_cmd_if;
  logic start_read;
  logic start_write;
  logic start_result;
  bbm_pkg::word_addr_t word_addr;
  bbm_pkg::word_t wdata;
  logic prog_mode;
  bbm_pkg::pulse_len_t pulse_len;
  bbm_pkg::operand_t [bbm_pkg::NUM_LANES-1:0] operands;
  logic done;

  modport regs (
    output start_read, start_write, start_result, word_addr, wdata,
    output prog_mode, pulse_len, operands,
    input  done
  );
  modport seq (
    input  start_read, start_write, start_result, word_addr, wdata,
    input  prog_mode, pulse_len, operands,
    output done
  );
endinterface

// File: hdl/host_regs.sv
// host command decode and registers
module host_regs (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_valid,
  input  logic cmd_write,
  input  bbm_pkg::host_addr_t cmd_addr,
  input  bbm_pkg::word_t cmd_wdata,
  output logic cmd_ready,
  output logic rsp_valid,
  output bbm_pkg::word_t rsp_rdata,
  seq_cmd_if.regs cmd,
  input  bbm_pkg::word_t [bbm_pkg::NUM_LANES-1:0] lane_words
);
  bbm_pkg::host_addr_t lat_addr;
  logic lat_write;
  bbm_pkg::word_t lat_wdata;
  logic accept;
  logic is_mem;
  logic reg_pend;
  logic reg_done;
  bbm_pkg::word_t reg_rdata;
  bbm_pkg::word_t arr_rdata;

  assign accept = cmd_valid && cmd_ready;
  assign is_mem = cmd_addr < bbm_pkg::MEM_LIMIT;
  assign cmd.word_addr = lat_addr[12:2];
  assign cmd.wdata = lat_wdata;

  always_ff @(posedge clk) begin
    if (accept) begin
      lat_addr  <= cmd_addr;
      lat_write <= cmd_write;
      lat_wdata <= cmd_wdata;
    end
  end

  always_comb begin
    reg_rdata = '0;
    if (lat_addr == bbm_pkg::MODE_ADDR) reg_rdata = bbm_pkg::word_t'(cmd.prog_mode);
    if (lat_addr == bbm_pkg::PULSE_ADDR) reg_rdata = bbm_pkg::word_t'(cmd.pulse_len);
    for (int k = 0; k < bbm_pkg::NUM_LANES; k++) begin
      if (lat_addr == bbm_pkg::host_addr_t'(bbm_pkg::OPERAND_BASE + 4 * k))
        reg_rdata = bbm_pkg::word_t'(cmd.operands[k]);
    end
  end

  // a memory read takes one whole lane and the result one byte per lane
  always_comb begin
    arr_rdata = lane_words[cmd.word_addr[10:9]];
    if (lat_addr == bbm_pkg::RESULT_ADDR) begin
      for (int k = 0; k < bbm_pkg::NUM_LANES; k++) begin
        arr_rdata[k*bbm_pkg::BYTE_BITS +: bbm_pkg::BYTE_BITS] =
          bbm_pkg::lane_byte_t'(lane_words[k]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_ready <= 1'b1;
      rsp_valid <= 1'b0;
      rsp_rdata <= '0;
      reg_pend <= 1'b0;
      reg_done <= 1'b0;
      cmd.start_read <= 1'b0;
      cmd.start_write <= 1'b0;
      cmd.start_result <= 1'b0;
      cmd.prog_mode <= 1'b0;
      cmd.pulse_len <= bbm_pkg::PULSE_RESET_VALUE;
      cmd.operands <= '0;
    end else begin
      rsp_valid <= 1'b0;
      cmd.start_read <= accept && !cmd_write && is_mem;
      cmd.start_write <= accept && cmd_write && is_mem;
      cmd.start_result <= accept && !cmd_write && (cmd_addr == bbm_pkg::RESULT_ADDR);
      // everything outside memory and the result read is answered here
      reg_pend <= accept && !is_mem && (cmd_write || cmd_addr != bbm_pkg::RESULT_ADDR);
      reg_done <= reg_pend;
      if (accept) cmd_ready <= 1'b0;
      if (reg_pend && lat_write) begin
        if (lat_addr == bbm_pkg::MODE_ADDR) cmd.prog_mode <= lat_wdata[0];
        if (lat_addr == bbm_pkg::PULSE_ADDR) cmd.pulse_len <= bbm_pkg::pulse_len_t'(lat_wdata);
        for (int k = 0; k < bbm_pkg::NUM_LANES; k++) begin
          if (lat_addr == bbm_pkg::host_addr_t'(bbm_pkg::OPERAND_BASE + 4 * k))
            cmd.operands[k] <= bbm_pkg::operand_t'(lat_wdata);
        end
      end
      if (reg_done || cmd.done) begin
        rsp_valid <= 1'b1;
        cmd_ready <= 1'b1;
        rsp_rdata <= lat_write ? '0 : (reg_done ? reg_rdata : arr_rdata);
      end
    end
  end

endmodule

// File: hdl/array_sequencer.sv
// array pin sequencer
module array_sequencer (
  input  logic clk,
  input  logic rst_n,
  seq_cmd_if.seq cmd,
  output bbm_pkg::cell_row_t chip_row,
  output bbm_pkg::cell_col_t chip_col,
  output logic chip_wl,
  output logic chip_bl,
  output logic chip_blen,
  output logic chip_sl,
  output logic chip_sense,
  output logic chip_read_out,
  output logic shift,
  output logic clear
);
  bbm_pkg::seq_state_t state, state_n;
  logic [4:0] bit_cnt, bit_n;
  logic [1:0] pass_cnt, pass_n;
  logic [2:0] phase_cnt, phase_n;
  bbm_pkg::pulse_len_t pulse_cnt, pulse_n;
  logic result_mode, result_n;
  bbm_pkg::cell_row_t row_n;
  bbm_pkg::cell_col_t col_n;
  logic is_write_n;

  always_comb begin
    state_n = state;
    bit_n = bit_cnt;
    pass_n = pass_cnt;
    phase_n = phase_cnt;
    pulse_n = pulse_cnt;
    result_n = result_mode;
    case (state)
      bbm_pkg::IDLE: begin
        bit_n = '0;
        pass_n = '0;
        phase_n = '0;
        pulse_n = '0;
        if (cmd.start_write) begin
          state_n = bbm_pkg::WR_ADDR;
        end else if (cmd.start_read || cmd.start_result) begin
          state_n = bbm_pkg::RD_SETUP;
          result_n = cmd.start_result;
        end
      end
      bbm_pkg::RD_SETUP: begin
        phase_n = phase_cnt + 3'd1;
        if (phase_cnt == 3'd1) begin
          phase_n = '0;
          state_n = bbm_pkg::RD_PRECHARGE;
        end
      end
      bbm_pkg::RD_PRECHARGE: state_n = bbm_pkg::RD_PULSE;
      bbm_pkg::RD_PULSE: begin
        phase_n = phase_cnt + 3'd1;
        if (phase_cnt == 3'd1) begin
          phase_n = '0;
          state_n = bbm_pkg::RD_PAUSE;
        end
      end
      // inference senses all four operands before a single read-out
      bbm_pkg::RD_PAUSE: begin
        state_n = bbm_pkg::RD_OUT;
        if (result_mode && pass_cnt != 2'(bbm_pkg::NUM_PASSES - 1)) begin
          pass_n = pass_cnt + 2'd1;
          state_n = bbm_pkg::RD_SETUP;
        end
      end
      bbm_pkg::RD_OUT: begin
        phase_n = phase_cnt + 3'd1;
        if (phase_cnt == 3'(bbm_pkg::BYTE_BITS - 1)) begin
          phase_n = '0;
          pass_n = pass_cnt + 2'd1;
          state_n = bbm_pkg::RD_SETUP;
          if (result_mode || pass_cnt == 2'(bbm_pkg::NUM_PASSES - 1)) state_n = bbm_pkg::IDLE;
        end
      end
      bbm_pkg::WR_ADDR: state_n = bbm_pkg::WR_PRECHARGE;
      bbm_pkg::WR_PRECHARGE: begin
        phase_n = phase_cnt + 3'd1;
        if (phase_cnt == 3'(bbm_pkg::PRECHARGE_CYCLES - 1)) begin
          phase_n = '0;
          state_n = bbm_pkg::WR_PULSE;
        end
      end
      // pulse_len + 1 cycles with the word line up
      bbm_pkg::WR_PULSE: begin
        pulse_n = pulse_cnt + 16'd1;
        if (pulse_cnt == cmd.pulse_len) begin
          pulse_n = '0;
          state_n = bbm_pkg::WR_CUTOFF;
        end
      end
      bbm_pkg::WR_CUTOFF: begin
        bit_n = bit_cnt + 5'd1;
        state_n = bbm_pkg::WR_ADDR;
        if (bit_cnt == 5'(bbm_pkg::WORD_BITS - 1)) state_n = bbm_pkg::IDLE;
      end
      default: state_n = bbm_pkg::IDLE;
    endcase
  end

  // pins decoded from the next state so they leave a flop
  always_comb begin
    is_write_n = state_n inside {bbm_pkg::WR_ADDR, bbm_pkg::WR_PRECHARGE,
                                 bbm_pkg::WR_PULSE, bbm_pkg::WR_CUTOFF};
    row_n = '0;
    col_n = '0;
    if (is_write_n) begin
      row_n = {cmd.word_addr[10:9], cmd.word_addr[6:1]};
      col_n = {cmd.word_addr[8:7], cmd.word_addr[0], bit_n};
    end else if (state_n != bbm_pkg::IDLE && result_n) begin
      row_n = {2'b00, cmd.operands[pass_n][8:3]};
      col_n = {pass_n, 3'b000, cmd.operands[pass_n][2:0]};
    end else if (state_n != bbm_pkg::IDLE) begin
      // pass p reads byte 3-p so the word fills MSB first
      row_n = {cmd.word_addr[10:9], cmd.word_addr[6:1]};
      col_n = {cmd.word_addr[8:7], cmd.word_addr[0], ~pass_n, 3'b000};
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= bbm_pkg::IDLE;
      bit_cnt <= '0;
      pass_cnt <= '0;
      phase_cnt <= '0;
      pulse_cnt <= '0;
      result_mode <= 1'b0;
      chip_row <= '0;
      chip_col <= '0;
      chip_wl <= 1'b0;
      chip_bl <= 1'b0;
      chip_blen <= 1'b0;
      chip_sl <= 1'b0;
      chip_sense <= 1'b0;
      chip_read_out <= 1'b0;
      clear <= 1'b0;
      cmd.done <= 1'b0;
    end else begin
      state <= state_n;
      bit_cnt <= bit_n;
      pass_cnt <= pass_n;
      phase_cnt <= phase_n;
      pulse_cnt <= pulse_n;
      result_mode <= result_n;
      chip_row <= row_n;
      chip_col <= col_n;
      chip_wl <= state_n == bbm_pkg::WR_PULSE;
      chip_bl <= (state_n inside {bbm_pkg::WR_PRECHARGE, bbm_pkg::WR_PULSE}) && cmd.wdata[bit_n];
      chip_blen <= is_write_n;
      chip_sl <= is_write_n && state_n != bbm_pkg::WR_ADDR && cmd.prog_mode;
      chip_sense <= state_n == bbm_pkg::RD_PULSE;
      chip_read_out <= state_n == bbm_pkg::RD_OUT;
      clear <= state == bbm_pkg::IDLE && state_n != bbm_pkg::IDLE;
      cmd.done <= state != bbm_pkg::IDLE && state_n == bbm_pkg::IDLE;
    end
  end

  // array presents one bit per lane in each read-out cycle
  assign shift = chip_read_out;

endmodule

// File: hdl/lane_shifter.sv
// lane serial capture
module lane_shifter (
  input  logic clk,
  input  logic rst_n,
  input  logic clear,
  input  logic shift,
  input  logic bit_in,
  output bbm_pkg::word_t word
);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      word <= '0;
    end else if (clear) begin
      word <= '0;
    end else if (shift) begin
      // msb arrives first
      word <= {word[bbm_pkg::WORD_BITS-2:0], bit_in};
    end
  end

endmodule

// File: hdl/bbm_top.sv
// bayesian memory controller top
module bbm_top (
  input  logic clk,
  input  logic rst_n,
  input  logic cmd_valid,
  input  logic cmd_write,
  input  bbm_pkg::host_addr_t cmd_addr,
  input  bbm_pkg::word_t cmd_wdata,
  output logic cmd_ready,
  output logic rsp_valid,
  output bbm_pkg::word_t rsp_rdata,
  output bbm_pkg::cell_row_t chip_row,
  output bbm_pkg::cell_col_t chip_col,
  output logic chip_wl,
  output logic chip_bl,
  output logic chip_blen,
  output logic chip_sl,
  output logic chip_sense,
  output logic chip_read_out,
  input  logic [bbm_pkg::NUM_LANES-1:0] chip_bits
);
  bbm_pkg::word_t [bbm_pkg::NUM_LANES-1:0] lane_words;
  logic shift;
  logic clear;

  seq_cmd_if cmd_bus ();

  host_regs u_regs (
    .clk(clk),
    .rst_n(rst_n),
    .cmd_valid(cmd_valid),
    .cmd_write(cmd_write),
    .cmd_addr(cmd_addr),
    .cmd_wdata(cmd_wdata),
    .cmd_ready(cmd_ready),
    .rsp_valid(rsp_valid),
    .rsp_rdata(rsp_rdata),
    .cmd(cmd_bus.regs),
    .lane_words(lane_words)
  );

  array_sequencer u_seq (
    .clk(clk),
    .rst_n(rst_n),
    .cmd(cmd_bus.seq),
    .chip_row(chip_row),
    .chip_col(chip_col),
    .chip_wl(chip_wl),
    .chip_bl(chip_bl),
    .chip_blen(chip_blen),
    .chip_sl(chip_sl),
    .chip_sense(chip_sense),
    .chip_read_out(chip_read_out),
    .shift(shift),
    .clear(clear)
  );

  // one capture register per array lane
  for (genvar k = 0; k < bbm_pkg::NUM_LANES; k++) begin : g_lane
    lane_shifter u_lane (
      .clk(clk),
      .rst_n(rst_n),
      .clear(clear),
      .shift(shift),
      .bit_in(chip_bits[k]),
      .word(lane_words[k])
    );
  end

endmodule

// File: verif/array_model.sv
// resistive array behavioral model
module array_model (
  input  logic clk,
  input  bbm_pkg::cell_row_t chip_row,
  input  bbm_pkg::cell_col_t chip_col,
  input  logic chip_wl,
  input  logic chip_bl,
  input  logic chip_blen,
  input  logic chip_sl,
  input  logic chip_sense,
  input  logic chip_read_out,
  output logic [bbm_pkg::NUM_LANES-1:0] chip_bits
);
  timeunit 1ns;
  timeprecision 100ps;

  logic cells [0:65535];
  bbm_pkg::lane_byte_t counts [bbm_pkg::NUM_LANES];
  logic [2:0] sense_falls = '0;
  logic [2:0] out_idx = '0;
  logic sense_q = 1'b0;
  logic read_out_q = 1'b0;
  logic infer_out;

  initial begin
    foreach (counts[k]) counts[k] = '0;
  end

  // an inference shows up as four sense pulses ahead of one read-out
  assign infer_out = sense_falls == 3'(bbm_pkg::NUM_PASSES);

  always @(posedge clk) begin
    sense_q <= chip_sense;
    read_out_q <= chip_read_out;
    if (chip_wl && chip_blen && chip_bl) cells[{chip_row, chip_col}] <= chip_sl;
    if (sense_q && !chip_sense) begin
      sense_falls <= sense_falls + 3'd1;
      for (int k = 0; k < bbm_pkg::NUM_LANES; k++) begin
        if (cells[{2'(k), chip_row[5:0], chip_col}]) counts[k] <= counts[k] + 8'd1;
      end
    end
    out_idx <= chip_read_out ? out_idx + 3'd1 : 3'd0;
    // counts only live until the read-out after them
    if (read_out_q && !chip_read_out) begin
      sense_falls <= '0;
      foreach (counts[k]) counts[k] <= '0;
    end
  end

  // read-out cycle i shows bit 7-i
  always_comb begin
    chip_bits = '0;
    for (int k = 0; k < bbm_pkg::NUM_LANES; k++) begin
      if (chip_read_out && infer_out) begin
        chip_bits[k] = counts[k][~out_idx];
      end else if (chip_read_out) begin
        chip_bits[k] = cells[{2'(k), chip_row[5:0], chip_col[7:3], ~out_idx}];
      end
    end
  end

endmodule

// File: verif/bbm_checker.sv
// host handshake and pin assertions
module bbm_checker (
  input logic clk,
  input logic rst_n,
  input logic cmd_valid,
  input logic cmd_ready,
  input logic rsp_valid,
  input logic chip_wl,
  input logic chip_blen,
  input logic chip_sense
);
  timeunit 1ns;
  timeprecision 100ps;

  accept_drops_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid && cmd_ready |=> !cmd_ready)
    else $error("cmd_ready stayed high after a command was accepted");

  // ready only comes back together with the response
  ready_returns_with_rsp: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cmd_ready) |-> rsp_valid)
    else $error("cmd_ready rose without rsp_valid");

  rsp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_valid |=> !rsp_valid)
    else $error("rsp_valid lasted more than one cycle");

  wl_sense_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(chip_wl && chip_sense))
    else $error("chip_wl and chip_sense high together");

  wl_needs_blen: assert property (@(posedge clk) disable iff (!rst_n)
    chip_wl |-> chip_blen)
    else $error("chip_wl high without chip_blen");

endmodule

bind bbm_top bbm_checker u_checker (.*);

// File: verif/tb_top.sv
// controller testbench
module tb_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_REG = 12;
  localparam int N_WR = 10;
  localparam int N_INF = 6;
  localparam int MAX_PULSE = 6;
  localparam int MAX_CMDS = 8 + 2 * N_REG + 2 * (1 + 3 * N_WR) + 7 * N_INF;
  localparam int RSP_LIMIT = 32 * (MAX_PULSE + 8) * 2;
  localparam longint WATCHDOG_NS = longint'(MAX_CMDS) * 32 * (MAX_PULSE + 8) * 100 * 2;

  logic clk = 1'b0;
  logic rst_n;
  logic cmd_valid;
  logic cmd_write;
  bbm_pkg::host_addr_t cmd_addr;
  bbm_pkg::word_t cmd_wdata;
  logic cmd_ready;
  logic rsp_valid;
  bbm_pkg::word_t rsp_rdata;
  bbm_pkg::cell_row_t chip_row;
  bbm_pkg::cell_col_t chip_col;
  logic chip_wl;
  logic chip_bl;
  logic chip_blen;
  logic chip_sl;
  logic chip_sense;
  logic chip_read_out;
  logic [bbm_pkg::NUM_LANES-1:0] chip_bits;

  logic [31:0] rand_state = 32'h538c;
  logic cells_ref [0:65535];
  logic reg_mode;
  bbm_pkg::pulse_len_t reg_pulse;
  bbm_pkg::operand_t reg_ops [bbm_pkg::NUM_LANES];
  int pass_count = 0;
  int fail_count = 0;
  int accept_count = 0;
  int rsp_count = 0;
  logic in_flight = 1'b0;
  int wl_run = 0;
  bbm_pkg::pulse_len_t wl_runs [$];

  bbm_top DUT (
    .clk(clk),
    .rst_n(rst_n),
    .cmd_valid(cmd_valid),
    .cmd_write(cmd_write),
    .cmd_addr(cmd_addr),
    .cmd_wdata(cmd_wdata),
    .cmd_ready(cmd_ready),
    .rsp_valid(rsp_valid),
    .rsp_rdata(rsp_rdata),
    .chip_row(chip_row),
    .chip_col(chip_col),
    .chip_wl(chip_wl),
    .chip_bl(chip_bl),
    .chip_blen(chip_blen),
    .chip_sl(chip_sl),
    .chip_sense(chip_sense),
    .chip_read_out(chip_read_out),
    .chip_bits(chip_bits)
  );

  array_model u_array (
    .clk(clk),
    .chip_row(chip_row),
    .chip_col(chip_col),
    .chip_wl(chip_wl),
    .chip_bl(chip_bl),
    .chip_blen(chip_blen),
    .chip_sl(chip_sl),
    .chip_sense(chip_sense),
    .chip_read_out(chip_read_out),
    .chip_bits(chip_bits)
  );

  always #50 clk = ~clk;

  initial begin
    #(WATCHDOG_NS);
    $display("timed out after %0d ns before the tests finished", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  // a response retires before a new accept in the same cycle
  always @(posedge clk) begin
    if (rst_n) begin
      if (rsp_valid) begin
        if (!in_flight) begin
          $display("response arrived with no command in progress");
          fail_count++;
        end
        rsp_count++;
        in_flight = 1'b0;
      end
      if (cmd_valid && cmd_ready) begin
        if (in_flight) begin
          $display("command accepted while another was in progress");
          fail_count++;
        end
        accept_count++;
        in_flight = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (chip_wl) begin
      wl_run++;
    end else if (wl_run != 0) begin
      wl_runs.push_back(bbm_pkg::pulse_len_t'(wl_run));
      wl_run = 0;
    end
  end

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic int rand_below(int n);
    return int'((next_rand() >> 8) % n);
  endfunction

  // few rows so reads and inference hit earlier writes
  function automatic bbm_pkg::word_addr_t random_word_addr();
    bbm_pkg::word_addr_t wa;
    wa = '0;
    wa[10:9] = 2'(rand_below(4));
    wa[8:7] = 2'(rand_below(4));
    wa[2:1] = 2'(rand_below(4));
    wa[0] = 1'(rand_below(2));
    return wa;
  endfunction

  function automatic bbm_pkg::operand_t random_operand();
    bbm_pkg::operand_t op;
    op = '0;
    op[4:3] = 2'(rand_below(4));
    op[2:0] = 3'(rand_below(8));
    return op;
  endfunction

  function automatic bbm_pkg::host_addr_t mem_addr(bbm_pkg::word_addr_t wa);
    return bbm_pkg::host_addr_t'({wa, 2'b00});
  endfunction

  function automatic bbm_pkg::host_addr_t operand_addr(int k);
    return bbm_pkg::host_addr_t'(bbm_pkg::OPERAND_BASE + 4 * k);
  endfunction

  // bit b of a word sits at row {a10:9, a6:1} and column {a8:7, a0, b}
  function automatic int word_cell(bbm_pkg::word_addr_t wa, int b);
    logic [15:0] idx;
    idx = {wa[10:9], wa[6:1], wa[8:7], wa[0], 5'(b)};
    return int'(idx);
  endfunction

  function automatic bbm_pkg::word_t model_word(bbm_pkg::word_addr_t wa);
    bbm_pkg::word_t w;
    for (int b = 0; b < bbm_pkg::WORD_BITS; b++) w[b] = cells_ref[word_cell(wa, b)];
    return w;
  endfunction

  function automatic bbm_pkg::word_t model_result();
    bbm_pkg::word_t r;
    bbm_pkg::lane_byte_t cnt;
    logic [15:0] idx;
    r = '0;
    for (int k = 0; k < bbm_pkg::NUM_LANES; k++) begin
      cnt = '0;
      for (int p = 0; p < bbm_pkg::NUM_PASSES; p++) begin
        idx = {2'(k), reg_ops[p][8:3], 2'(p), 3'b000, reg_ops[p][2:0]};
        cnt = cnt + bbm_pkg::lane_byte_t'(cells_ref[idx]);
      end
      r[k*8 +: 8] = cnt;
    end
    return r;
  endfunction

  task automatic check_word(input string name, input bbm_pkg::word_t got,
                            input bbm_pkg::word_t exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input bbm_pkg::pulse_len_t got,
                           input bbm_pkg::pulse_len_t exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got === exp) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("[FAIL] %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("%s: %0d errors", name, fail_count - fails_before);
  endtask

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic put_cmd(input logic write, input bbm_pkg::host_addr_t addr,
                         input bbm_pkg::word_t data);
    cmd_valid = 1'b1;
    cmd_write = write;
    cmd_addr = addr;
    cmd_wdata = data;
  endtask

  task automatic wait_accept();
    while (!cmd_ready) step();
    step();
  endtask

  task automatic wait_rsp(output bbm_pkg::word_t rdata);
    int waited;
    waited = 0;
    rdata = '0;
    while (!rsp_valid && waited < RSP_LIMIT) begin
      step();
      waited++;
    end
    if (rsp_valid) begin
      rdata = rsp_rdata;
    end else begin
      $display("no response within %0d cycles", RSP_LIMIT);
      fail_count++;
    end
  endtask

  task automatic send_cmd(input logic write, input bbm_pkg::host_addr_t addr,
                          input bbm_pkg::word_t data, output bbm_pkg::word_t rdata);
    put_cmd(write, addr, data);
    wait_accept();
    cmd_valid = 1'b0;
    wait_rsp(rdata);
  endtask

  task automatic read_defaults();
    bbm_pkg::word_t rd;
    int fails_before;
    fails_before = fail_count;
    send_cmd(1'b0, bbm_pkg::MODE_ADDR, '0, rd);
    check_word("rsp_rdata mode", rd, 32'd0);
    send_cmd(1'b0, bbm_pkg::PULSE_ADDR, '0, rd);
    check_word("rsp_rdata pulse", rd, 32'd1);
    for (int k = 0; k < bbm_pkg::NUM_LANES; k++) begin
      send_cmd(1'b0, operand_addr(k), '0, rd);
      check_word("rsp_rdata operand", rd, 32'd0);
    end
    report_test("register defaults", fails_before);
  endtask

  task automatic register_readback();
    bbm_pkg::word_t rd;
    bbm_pkg::word_t data;
    bbm_pkg::word_t expect_val;
    bbm_pkg::host_addr_t addr;
    int sel;
    int fails_before;
    fails_before = fail_count;
    for (int n = 0; n < N_REG; n++) begin
      sel = rand_below(6);
      data = next_rand();
      case (sel)
        0: begin
          addr = bbm_pkg::MODE_ADDR;
          expect_val = bbm_pkg::word_t'(data[0]);
          reg_mode = data[0];
        end
        1: begin
          addr = bbm_pkg::PULSE_ADDR;
          expect_val = bbm_pkg::word_t'(data[15:0]);
          reg_pulse = data[15:0];
        end
        default: begin
          addr = operand_addr(sel - 2);
          expect_val = bbm_pkg::word_t'(data[8:0]);
          reg_ops[sel-2] = data[8:0];
        end
      endcase
      send_cmd(1'b1, addr, data, rd);
      check_word("rsp_rdata register write", rd, 32'd0);
      send_cmd(1'b0, addr, '0, rd);
      check_word("rsp_rdata register readback", rd, expect_val);
    end
    report_test("register readback", fails_before);
  endtask

  task automatic write_and_verify();
    bbm_pkg::word_t rd;
    bbm_pkg::word_t data;
    bbm_pkg::word_addr_t wa;
    bbm_pkg::pulse_len_t plen;
    plen = bbm_pkg::pulse_len_t'(1 + rand_below(MAX_PULSE));
    send_cmd(1'b1, bbm_pkg::PULSE_ADDR, bbm_pkg::word_t'(plen), rd);
    reg_pulse = plen;
    wa = random_word_addr();
    data = next_rand();
    wl_runs.delete();
    send_cmd(1'b1, mem_addr(wa), data, rd);
    check_word("rsp_rdata memory write", rd, 32'd0);
    check_flag("chip_wl pulse count is 32", wl_runs.size() == 32, 1'b1);
    foreach (wl_runs[i]) check_len("chip_wl run length", wl_runs[i], plen + 16'd1);
    for (int b = 0; b < bbm_pkg::WORD_BITS; b++) begin
      if (data[b]) cells_ref[word_cell(wa, b)] = reg_mode;
    end
    send_cmd(1'b0, mem_addr(wa), '0, rd);
    check_word("rsp_rdata memory read", rd, model_word(wa));
  endtask

  task automatic program_words(input logic mode);
    bbm_pkg::word_t rd;
    int fails_before;
    fails_before = fail_count;
    send_cmd(1'b1, bbm_pkg::MODE_ADDR, bbm_pkg::word_t'(mode), rd);
    reg_mode = mode;
    repeat (N_WR) write_and_verify();
    report_test(mode ? "set-mode writes" : "reset-mode writes", fails_before);
  endtask

  task automatic inference_reads();
    bbm_pkg::word_t rd;
    bbm_pkg::word_t expect_res;
    bbm_pkg::operand_t op;
    int fails_before;
    fails_before = fail_count;
    for (int n = 0; n < N_INF; n++) begin
      for (int p = 0; p < bbm_pkg::NUM_PASSES; p++) begin
        op = random_operand();
        send_cmd(1'b1, operand_addr(p), bbm_pkg::word_t'(op), rd);
        reg_ops[p] = op;
      end
      expect_res = model_result();
      send_cmd(1'b0, bbm_pkg::RESULT_ADDR, '0, rd);
      check_word("rsp_rdata result", rd, expect_res);
      send_cmd(1'b1, bbm_pkg::RESULT_ADDR, next_rand(), rd);
      check_word("rsp_rdata result write", rd, 32'd0);
      send_cmd(1'b0, bbm_pkg::RESULT_ADDR, '0, rd);
      check_word("rsp_rdata result after write", rd, expect_res);
    end
    report_test("inference reads", fails_before);
  endtask

  // second command stays valid while the first is busy
  task automatic held_valid();
    bbm_pkg::word_t rd;
    bbm_pkg::word_addr_t wa;
    int accepts_before;
    int fails_before;
    fails_before = fail_count;
    wa = random_word_addr();
    put_cmd(1'b0, mem_addr(wa), '0);
    wait_accept();
    accepts_before = accept_count;
    put_cmd(1'b0, bbm_pkg::PULSE_ADDR, '0);
    wait_rsp(rd);
    check_word("rsp_rdata held memory read", rd, model_word(wa));
    check_flag("held command accepted while busy", accept_count != accepts_before, 1'b0);
    wait_accept();
    cmd_valid = 1'b0;
    wait_rsp(rd);
    check_word("rsp_rdata held pulse read", rd, bbm_pkg::word_t'(reg_pulse));
    step();
    check_flag("one response per command", accept_count == rsp_count, 1'b1);
    report_test("held valid", fails_before);
  endtask

  initial begin
    rst_n = 1'b0;
    cmd_valid = 1'b0;
    cmd_write = 1'b0;
    cmd_addr = '0;
    cmd_wdata = '0;
    reg_mode = 1'b0;
    reg_pulse = 16'd1;
    foreach (reg_ops[k]) reg_ops[k] = '0;
    for (int i = 0; i < 65536; i++) begin
      cells_ref[i] = ^i[15:0];
      u_array.cells[i] = ^i[15:0];
    end
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    step();
    read_defaults();
    register_readback();
    program_words(1'b1);
    program_words(1'b0);
    inference_reads();
    held_valid();
    repeat (4) step();
    $display("checks passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: project.f
hdl/bbm_pkg.sv
hdl/seq_cmd_if.sv
hdl/host_regs.sv
hdl/array_sequencer.sv
hdl/lane_shifter.sv
hdl/bbm_top.sv
verif/array_model.sv
verif/bbm_checker.sv
verif/tb_top.sv
